// File: flist.f
lpif_pkg.sv
ll_auto_sync.sv
lpif_name.sv
lpif_concat.sv
lpif_link_top.sv
tb_lpif_link.sv

// File: ll_auto_sync.sv
// Delays counted in clk_wr cycles; marker alternation and strobe lock assume 2 channels
`default_nettype none

module ll_auto_sync import lpif_pkg::*; (
  input  logic    clk_wr,
  input  logic    rst,
  input  logic    tx_online,
  input  logic    rx_online,
  input  delay_t  delay_x_value,
  input  delay_t  delay_y_value,
  input  delay_t  delay_z_value,
  input  marker_t tx_mrk_userbit,
  input  logic    tx_stb_userbit,
  output logic    tx_online_delay,
  output logic    rx_online_delay,
  output logic    tx_auto_stb_userbit,
  output marker_t tx_auto_mrk_userbit
);

  delay_t      rx_cnt;
  delay_t      sync_cnt;
  sync_state_t sync_state;
  logic        mrk_phase;

  ////////////////////
  // Rx online qualify

  // Count consecutive online cycles, drop at once on rx_online low
  always_ff @(posedge clk_wr) begin
    if (rst || !rx_online) begin
      rx_cnt          <= '0;
      rx_online_delay <= 1'b0;
    end else if (rx_cnt >= delay_x_value) begin
      rx_online_delay <= 1'b1;
    end else begin
      rx_cnt <= rx_cnt + 1'b1;
    end
  end

  ////////////////////
  // Tx sequencer

  // Shared counter: delay_y to go online, then delay_z to lock strobe
  always_ff @(posedge clk_wr) begin
    if (rst || !tx_online) begin
      sync_state <= SYNC_OFFLINE;
      sync_cnt   <= '0;
    end else begin
      case (sync_state)
        SYNC_OFFLINE: begin
          sync_state <= SYNC_WAIT_ONLINE;
          sync_cnt   <= '0;
        end
        SYNC_WAIT_ONLINE: begin
          if (sync_cnt >= delay_y_value) begin
            sync_state <= SYNC_WAIT_STROBE;
            sync_cnt   <= '0;
          end else begin
            sync_cnt <= sync_cnt + 1'b1;
          end
        end
        SYNC_WAIT_STROBE: begin
          if (sync_cnt >= delay_z_value) begin
            sync_state <= SYNC_RUN;
          end else begin
            sync_cnt <= sync_cnt + 1'b1;
          end
        end
        default: sync_state <= SYNC_RUN;
      endcase
    end
  end

  // Online from strobe wait onward
  assign tx_online_delay = (sync_state == SYNC_WAIT_STROBE) || (sync_state == SYNC_RUN);

  // Beat phase, first online beat is phase 0
  always_ff @(posedge clk_wr) begin
    if (rst || !tx_online_delay) begin
      mrk_phase <= 1'b0;
    end else begin
      mrk_phase <= ~mrk_phase;
    end
  end

  ////////////////////
  // Userbit override

  // Strobe persistent once locked
  assign tx_auto_stb_userbit = (sync_state == SYNC_RUN) ? 1'b1 : tx_stb_userbit;

  // Marker 01, 10, 01, ... while online
  assign tx_auto_mrk_userbit = !tx_online_delay ? tx_mrk_userbit :
                               mrk_phase        ? marker_t'(2'b10) : marker_t'(2'b01);

endmodule

`default_nettype wire

// File: lpif_concat.sv
// Two-channel striping only; received userbits are ignored, no deskew between channels
`default_nettype none

module lpif_concat import lpif_pkg::*; (
  input  logic       clk_wr,
  input  logic       rst,
  input  logic       tx_online,
  input  logic       rx_online,
  input  logic       tx_stb_userbit,
  input  lpif_flit_t tx_downstream_data,
  input  phy_word_t  rx_phy0,
  input  phy_word_t  rx_phy1,
  input  marker_t    tx_mrk_userbit,
  output phy_word_t  tx_phy0,
  output phy_word_t  tx_phy1,
  output lpif_flit_t rx_upstream_data
);

  logic [FLIT_WIDTH-1:0] tx_word;
  half_word_t            tx_half0;
  half_word_t            tx_half1;
  phy_word_t             tx_beat0;
  phy_word_t             tx_beat1;

  half_word_t            rx_half0;
  half_word_t            rx_half1;
  logic [FLIT_WIDTH-1:0] rx_word;

  // Build one beat: half flit, strobe, marker, rest zero
  function automatic phy_word_t make_beat(half_word_t half, logic stb, logic mrk);
    phy_word_t beat;
    beat                   = '0;
    beat[HALF_WIDTH-1:0]   = half;
    beat[STB_BIT]          = stb;
    beat[MRK_BIT]          = mrk;
    return beat;
  endfunction

  ////////////////////
  // Transmit

  assign tx_word = tx_downstream_data;

  // Channel 0 low half, channel 1 high half
  assign tx_half0 = tx_word[HALF_WIDTH-1:0];
  assign tx_half1 = tx_word[FLIT_WIDTH-1:HALF_WIDTH];

  // Each channel carries its own marker bit
  assign tx_beat0 = make_beat(tx_half0, tx_stb_userbit, tx_mrk_userbit[0]);
  assign tx_beat1 = make_beat(tx_half1, tx_stb_userbit, tx_mrk_userbit[1]);

  // Quiet line while offline
  always_ff @(posedge clk_wr) begin
    if (rst || !tx_online) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else begin
      tx_phy0 <= tx_beat0;
      tx_phy1 <= tx_beat1;
    end
  end

  ////////////////////
  // Receive

  // Userbits above the half are dropped
  assign rx_half0 = rx_phy0[HALF_WIDTH-1:0];
  assign rx_half1 = rx_phy1[HALF_WIDTH-1:0];
  assign rx_word  = {rx_half1, rx_half0};

  // Zero word until rx is qualified online
  always_ff @(posedge clk_wr) begin
    if (rst || !rx_online) begin
      rx_upstream_data <= '0;
    end else begin
      rx_upstream_data <= lpif_flit_t'(rx_word);
    end
  end

endmodule

`default_nettype wire

// File: lpif_link_top.sv
// Single clock, no FIFO or credits: dstrm to tx_phy and rx_phy to ustrm are 2 cycles each
`default_nettype none

module lpif_link_top import lpif_pkg::*; (
  input  logic          clk_wr,
  input  logic          rst,

  // Link control
  input  logic          tx_online,
  input  logic          rx_online,

  // PHY channels
  output phy_word_t     tx_phy0,
  input  phy_word_t     rx_phy0,
  output phy_word_t     tx_phy1,
  input  phy_word_t     rx_phy1,

  // Downstream user fields
  input  lpif_state_t   dstrm_state,
  input  lpif_protid_t  dstrm_protid,
  input  lpif_data_t    dstrm_data,
  input  lpif_slot_t    dstrm_dvalid,
  input  lpif_crc_t     dstrm_crc,
  input  lpif_slot_t    dstrm_crc_valid,
  input  lpif_slot_t    dstrm_valid,

  // Upstream user fields
  output lpif_state_t   ustrm_state,
  output lpif_protid_t  ustrm_protid,
  output lpif_data_t    ustrm_data,
  output lpif_slot_t    ustrm_dvalid,
  output lpif_crc_t     ustrm_crc,
  output lpif_slot_t    ustrm_crc_valid,
  output lpif_slot_t    ustrm_valid,

  // Status
  output debug_status_t tx_downstream_debug_status,
  output debug_status_t rx_upstream_debug_status,

  // Config
  input  logic          m_gen2_mode,
  input  marker_t       tx_mrk_userbit,
  input  logic          tx_stb_userbit,
  input  delay_t        delay_x_value,
  input  delay_t        delay_y_value,
  input  delay_t        delay_z_value
);

  lpif_flit_t    txfifo_downstream_data;
  lpif_flit_t    rx_upstream_data;
  marker_t       tx_auto_mrk_userbit;
  logic          tx_auto_stb_userbit;
  logic          tx_online_delay;
  logic          rx_online_delay;
  debug_status_t debug_word;

  ////////////////////
  // Auto-sync

  ll_auto_sync u_auto_sync (
    .clk_wr              (clk_wr),
    .rst                 (rst),
    .tx_online           (tx_online),
    .rx_online           (rx_online),
    .delay_x_value       (delay_x_value),
    .delay_y_value       (delay_y_value),
    .delay_z_value       (delay_z_value),
    .tx_mrk_userbit      (tx_mrk_userbit),
    .tx_stb_userbit      (tx_stb_userbit),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_auto_stb_userbit (tx_auto_stb_userbit),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit)
  );

  ////////////////////
  // Debug status

  // Only the two online flags are live
  always_comb begin
    debug_word                    = '0;
    debug_word[DBG_TX_ONLINE_BIT] = tx_online_delay;
    debug_word[DBG_RX_ONLINE_BIT] = rx_online_delay;
  end

  assign tx_downstream_debug_status = debug_word;
  assign rx_upstream_debug_status   = debug_word;

  ////////////////////
  // User side pack/unpack

  // Logic-link FIFO bypassed, flit words connect straight through
  lpif_name u_name (
    .clk_wr                 (clk_wr),
    .rst                    (rst),
    .m_gen2_mode            (m_gen2_mode),
    .dstrm_state            (dstrm_state),
    .dstrm_protid           (dstrm_protid),
    .dstrm_data             (dstrm_data),
    .dstrm_dvalid           (dstrm_dvalid),
    .dstrm_crc              (dstrm_crc),
    .dstrm_crc_valid        (dstrm_crc_valid),
    .dstrm_valid            (dstrm_valid),
    .rxfifo_upstream_data   (rx_upstream_data),
    .txfifo_downstream_data (txfifo_downstream_data),
    .ustrm_state            (ustrm_state),
    .ustrm_protid           (ustrm_protid),
    .ustrm_data             (ustrm_data),
    .ustrm_dvalid           (ustrm_dvalid),
    .ustrm_crc              (ustrm_crc),
    .ustrm_crc_valid        (ustrm_crc_valid),
    .ustrm_valid            (ustrm_valid)
  );

  ////////////////////
  // PHY striping

  // Delayed online levels gate both directions
  lpif_concat u_concat (
    .clk_wr             (clk_wr),
    .rst                (rst),
    .tx_online          (tx_online_delay),
    .rx_online          (rx_online_delay),
    .tx_stb_userbit     (tx_auto_stb_userbit),
    .tx_downstream_data (txfifo_downstream_data),
    .rx_phy0            (rx_phy0),
    .rx_phy1            (rx_phy1),
    .tx_mrk_userbit     (tx_auto_mrk_userbit),
    .tx_phy0            (tx_phy0),
    .tx_phy1            (tx_phy1),
    .rx_upstream_data   (rx_upstream_data)
  );

endmodule

`default_nettype wire

// File: lpif_name.sv
// One register stage each way; gen1 clears slot-1 valids but leaves data and CRC untouched
`default_nettype none

module lpif_name import lpif_pkg::*; (
  input  logic         clk_wr,
  input  logic         rst,
  input  logic         m_gen2_mode,
  input  lpif_state_t  dstrm_state,
  input  lpif_protid_t dstrm_protid,
  input  lpif_data_t   dstrm_data,
  input  lpif_slot_t   dstrm_dvalid,
  input  lpif_crc_t    dstrm_crc,
  input  lpif_slot_t   dstrm_crc_valid,
  input  lpif_slot_t   dstrm_valid,
  input  lpif_flit_t   rxfifo_upstream_data,
  output lpif_flit_t   txfifo_downstream_data,
  output lpif_state_t  ustrm_state,
  output lpif_protid_t ustrm_protid,
  output lpif_data_t   ustrm_data,
  output lpif_slot_t   ustrm_dvalid,
  output lpif_crc_t    ustrm_crc,
  output lpif_slot_t   ustrm_crc_valid,
  output lpif_slot_t   ustrm_valid
);

  lpif_slot_t slot_mask;
  lpif_flit_t dstrm_flit;
  lpif_flit_t ustrm_q;

  // Gen1 uses slot 0 only
  assign slot_mask = m_gen2_mode ? 2'b11 : 2'b01;

  // Apply slot mask to every per-slot field
  function automatic lpif_flit_t mask_slots(lpif_flit_t flit, lpif_slot_t mask);
    lpif_flit_t res;
    res           = flit;
    res.dvalid    = flit.dvalid & mask;
    res.crc_valid = flit.crc_valid & mask;
    res.valid     = flit.valid & mask;
    return res;
  endfunction

  ////////////////////
  // Downstream pack

  assign dstrm_flit = '{state: dstrm_state, protid: dstrm_protid, data: dstrm_data,
                        dvalid: dstrm_dvalid, crc: dstrm_crc,
                        crc_valid: dstrm_crc_valid, valid: dstrm_valid};

  always_ff @(posedge clk_wr) begin
    if (rst) txfifo_downstream_data <= '0;
    else     txfifo_downstream_data <= mask_slots(dstrm_flit, slot_mask);
  end

  ////////////////////
  // Upstream unpack

  always_ff @(posedge clk_wr) begin
    if (rst) ustrm_q <= '0;
    else     ustrm_q <= mask_slots(rxfifo_upstream_data, slot_mask);
  end

  assign ustrm_state     = ustrm_q.state;
  assign ustrm_protid    = ustrm_q.protid;
  assign ustrm_data      = ustrm_q.data;
  assign ustrm_dvalid    = ustrm_q.dvalid;
  assign ustrm_crc       = ustrm_q.crc;
  assign ustrm_crc_valid = ustrm_q.crc_valid;
  assign ustrm_valid     = ustrm_q.valid;

endmodule

`default_nettype wire

// File: lpif_pkg.sv
// Shared LPIF types for the 2-channel half-rate master; flit layout is fixed at 290 bits
`default_nettype none

package lpif_pkg;

  ////////////////////
  // Widths and bit positions

  // Packed flit and its per-channel share
  localparam int FLIT_WIDTH = 290;
  localparam int HALF_WIDTH = 145;

  // One marker bit per PHY channel
  localparam int MARKER_WIDTH = 2;

  // Userbit positions inside a 160-bit beat, just above the flit half
  localparam int STB_BIT = 145;
  localparam int MRK_BIT = 146;

  // Online flags in the debug status words
  localparam int DBG_TX_ONLINE_BIT = 19;
  localparam int DBG_RX_ONLINE_BIT = 18;

  ////////////////////
  // Field types

  typedef logic [7:0]   lpif_state_t;
  typedef logic [3:0]   lpif_protid_t;
  typedef logic [255:0] lpif_data_t;
  // Bit 0 is flit slot 0, bit 1 is slot 1 (gen2 only)
  typedef logic [1:0]   lpif_slot_t;
  typedef logic [15:0]  lpif_crc_t;

  // PHY side
  typedef logic [159:0]            phy_word_t;
  typedef logic [HALF_WIDTH-1:0]   half_word_t;
  typedef logic [MARKER_WIDTH-1:0] marker_t;

  // Config and status
  typedef logic [15:0] delay_t;
  typedef logic [31:0] debug_status_t;

  ////////////////////
  // Flit word

  // MSB first; CRC carried as opaque data
  typedef struct packed {
    lpif_state_t  state;
    lpif_protid_t protid;
    lpif_data_t   data;
    lpif_slot_t   dvalid;
    lpif_crc_t    crc;
    lpif_slot_t   crc_valid;
    lpif_slot_t   valid;
  } lpif_flit_t;

  ////////////////////
  // Auto-sync tx sequencer

  typedef enum logic [1:0] {
    SYNC_OFFLINE,
    SYNC_WAIT_ONLINE,
    SYNC_WAIT_STROBE,
    SYNC_RUN
  } sync_state_t;

endpackage

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and decide the status from the simulation output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f flist.f --top-module tb_lpif_link -o sim_tb || exit 1
out="$(./obj_dir/sim_tb 2>&1)"
echo "$out"
grep -q "Simulation finished: PASS" <<< "$out" && echo "run.sh: ok" || {
  echo "run.sh: simulation did not pass"
  exit 1
}

// File: tb_lpif_link.sv
// Loopback testbench; tx_phy is wired straight back to rx_phy and all timing is in clk_wr cycles
`default_nettype none

module tb_lpif_link import lpif_pkg::*; ();

  localparam int          NUM_STIM = 8;
  localparam int          DELAY_X  = 6;
  localparam int          DELAY_Y  = 9;
  localparam int          DELAY_Z  = 3;
  localparam int          TIMEOUT  = 100;
  localparam logic [31:0] SEED     = 32'hec63bac3;

  // One stimulus row with an 8-char ASCII name
  typedef struct packed {
    logic [63:0]  name;
    logic         gen2;
    lpif_state_t  state;
    lpif_protid_t protid;
    lpif_slot_t   dvalid;
    lpif_slot_t   crc_valid;
    lpif_slot_t   valid;
    logic [7:0]   offset;
  } stim_t;

  // Model entry with the flit already masked on the downstream side
  typedef struct packed {
    logic [63:0] name;
    logic        gen2;
    lpif_flit_t  flit;
  } expect_t;

  logic          clk;
  logic          rst;
  logic          tx_online;
  logic          rx_online;
  logic          m_gen2_mode;
  logic          tx_stb_userbit;
  marker_t       tx_mrk_userbit;
  delay_t        delay_x_value;
  delay_t        delay_y_value;
  delay_t        delay_z_value;
  lpif_state_t   dstrm_state;
  lpif_protid_t  dstrm_protid;
  lpif_data_t    dstrm_data;
  lpif_slot_t    dstrm_dvalid;
  lpif_crc_t     dstrm_crc;
  lpif_slot_t    dstrm_crc_valid;
  lpif_slot_t    dstrm_valid;
  phy_word_t     tx_phy0;
  phy_word_t     tx_phy1;
  phy_word_t     rx_phy0;
  phy_word_t     rx_phy1;
  lpif_state_t   ustrm_state;
  lpif_protid_t  ustrm_protid;
  lpif_data_t    ustrm_data;
  lpif_slot_t    ustrm_dvalid;
  lpif_crc_t     ustrm_crc;
  lpif_slot_t    ustrm_crc_valid;
  lpif_slot_t    ustrm_valid;
  debug_status_t tx_downstream_debug_status;
  debug_status_t rx_upstream_debug_status;

  stim_t       stim_table [NUM_STIM];
  expect_t     model_q [$];
  int          errors;
  logic [31:0] rng;

  always #4 clk = ~clk;

  // External PHY loopback
  assign rx_phy0 = tx_phy0;
  assign rx_phy1 = tx_phy1;

  lpif_link_top u_dut (
    .clk_wr(clk), .rst(rst), .tx_online(tx_online), .rx_online(rx_online),
    .tx_phy0(tx_phy0), .rx_phy0(rx_phy0), .tx_phy1(tx_phy1), .rx_phy1(rx_phy1),
    .dstrm_state(dstrm_state), .dstrm_protid(dstrm_protid), .dstrm_data(dstrm_data),
    .dstrm_dvalid(dstrm_dvalid), .dstrm_crc(dstrm_crc),
    .dstrm_crc_valid(dstrm_crc_valid), .dstrm_valid(dstrm_valid),
    .ustrm_state(ustrm_state), .ustrm_protid(ustrm_protid), .ustrm_data(ustrm_data),
    .ustrm_dvalid(ustrm_dvalid), .ustrm_crc(ustrm_crc),
    .ustrm_crc_valid(ustrm_crc_valid), .ustrm_valid(ustrm_valid),
    .tx_downstream_debug_status(tx_downstream_debug_status),
    .rx_upstream_debug_status(rx_upstream_debug_status),
    .m_gen2_mode(m_gen2_mode), .tx_mrk_userbit(tx_mrk_userbit),
    .tx_stb_userbit(tx_stb_userbit), .delay_x_value(delay_x_value),
    .delay_y_value(delay_y_value), .delay_z_value(delay_z_value)
  );

  ////////////////////
  // Helpers

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Gen1 drops the slot-1 valid bits
  function automatic lpif_flit_t clear_slot1(input lpif_flit_t f);
    lpif_flit_t r;
    r              = f;
    r.dvalid[1]    = 1'b0;
    r.crc_valid[1] = 1'b0;
    r.valid[1]     = 1'b0;
    return r;
  endfunction

  // 0 rx online, 1 tx online, 2 strobe locked, 3 tx fully offline
  function automatic logic level_of(input int sel);
    case (sel)
      0:       return rx_upstream_debug_status[DBG_RX_ONLINE_BIT];
      1:       return tx_downstream_debug_status[DBG_TX_ONLINE_BIT];
      2:       return tx_phy0[STB_BIT] && tx_phy1[STB_BIT];
      default: return !tx_downstream_debug_status[DBG_TX_ONLINE_BIT] &&
                      tx_phy0 == '0 && tx_phy1 == '0;
    endcase
  endfunction

  // Poll once per cycle at the falling edge until TIMEOUT
  task automatic wait_for_level(input int sel, input string what, output int cycles);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!level_of(sel) && n < TIMEOUT);
    if (!level_of(sel)) begin
      $display("ERROR: timed out after %0d cycles waiting for %s", n, what);
      errors++;
    end
    cycles = n;
  endtask

  task automatic check_offline(input string what);
    if (tx_phy0 != '0 || tx_phy1 != '0) begin
      $display("mismatch %s tx_phy: exp=0 act=%h %h", what, tx_phy0, tx_phy1);
      errors++;
    end
    if (ustrm_valid != '0) begin
      $display("mismatch %s ustrm_valid: exp=0 act=%b", what, ustrm_valid);
      errors++;
    end
    if (tx_downstream_debug_status != '0 || rx_upstream_debug_status != '0) begin
      $display("mismatch %s debug: exp=0 act=%h %h", what,
               tx_downstream_debug_status, rx_upstream_debug_status);
      errors++;
    end
  endtask

  ////////////////////
  // Main sequence

  initial begin
    expect_t               cur;
    lpif_flit_t            want;
    lpif_flit_t            got;
    logic [FLIT_WIDTH-1:0] phy_ref;
    logic                  up_mode;
    logic                  prev_mrk;
    logic                  mrk0;
    debug_status_t         dbg_exp;
    int                    cycles;
    clk = 1'b0;
    rst = 1'b1;
    tx_online = 1'b0;
    rx_online = 1'b0;
    m_gen2_mode = 1'b1;
    tx_stb_userbit = 1'b0;
    tx_mrk_userbit = '0;
    delay_x_value = 16'(DELAY_X);
    delay_y_value = 16'(DELAY_Y);
    delay_z_value = 16'(DELAY_Z);
    {dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid,
     dstrm_crc, dstrm_crc_valid, dstrm_valid} = '0;
    errors = 0;
    rng = SEED;
    // Name, gen2, state, protid, dvalid, crc_valid, valid, seed offset
    stim_table[0] = '{"g2_all  ", 1'b1, 8'h11, 4'h1, 2'b11, 2'b11, 2'b11, 8'd1};
    stim_table[1] = '{"g2_slot0", 1'b1, 8'h22, 4'h2, 2'b01, 2'b01, 2'b01, 8'd2};
    stim_table[2] = '{"g2_slot1", 1'b1, 8'h33, 4'h3, 2'b10, 2'b10, 2'b10, 8'd3};
    stim_table[3] = '{"g2_mix  ", 1'b1, 8'h44, 4'h5, 2'b10, 2'b01, 2'b11, 8'd4};
    stim_table[4] = '{"g1_all  ", 1'b0, 8'h55, 4'h6, 2'b11, 2'b11, 2'b11, 8'd5};
    stim_table[5] = '{"g1_slot1", 1'b0, 8'h66, 4'h7, 2'b10, 2'b10, 2'b10, 8'd6};
    stim_table[6] = '{"g1_mix  ", 1'b0, 8'h77, 4'h8, 2'b11, 2'b01, 2'b10, 8'd7};
    stim_table[7] = '{"g2_back ", 1'b1, 8'h88, 4'hf, 2'b11, 2'b11, 2'b11, 8'd8};

    // Reset held for 5 rising edges
    repeat (4) begin
      @(negedge clk);
      check_offline("reset");
    end
    @(posedge clk);
    rst <= 1'b0;
    repeat (3) begin
      @(negedge clk);
      check_offline("offline");
    end

    // Online qualify delays
    @(posedge clk);
    rx_online <= 1'b1;
    wait_for_level(0, "rx online delay", cycles);
    if (cycles <= DELAY_X) begin
      $display("mismatch rx_delay: exp=>%0d cycles act=%0d", DELAY_X, cycles);
      errors++;
    end
    @(posedge clk);
    tx_online <= 1'b1;
    wait_for_level(1, "tx online delay", cycles);
    if (cycles <= DELAY_Y) begin
      $display("mismatch tx_delay: exp=>%0d cycles act=%0d", DELAY_Y, cycles);
      errors++;
    end
    // Strobe lock after delay_z more cycles
    wait_for_level(2, "strobe lock", cycles);
    if (cycles <= DELAY_Z) begin
      $display("mismatch strobe: exp=>%0d cycles act=%0d", DELAY_Z, cycles);
      errors++;
    end

    ////////////////////
    // Loopback table

    // Both online flags at bits 19 and 18, nothing else
    dbg_exp = 32'h000c_0000;
    // Pipeline holds idle zero flits so far
    cur = '0;
    cur.name = "prefill ";
    cur.gen2 = 1'b1;
    repeat (4) model_q.push_back(cur);
    prev_mrk = tx_phy0[MRK_BIT];
    for (int i = 0; i < NUM_STIM + 4; i++) begin
      @(posedge clk);
      // Upstream mask at this edge uses the mode driven one cycle earlier
      up_mode = m_gen2_mode;
      cur = '0;
      cur.name = "idle    ";
      cur.gen2 = 1'b1;
      if (i < NUM_STIM) begin
        cur.name = stim_table[i].name;
        cur.gen2 = stim_table[i].gen2;
        cur.flit.state = stim_table[i].state;
        cur.flit.protid = stim_table[i].protid;
        cur.flit.dvalid = stim_table[i].dvalid;
        cur.flit.crc_valid = stim_table[i].crc_valid;
        cur.flit.valid = stim_table[i].valid;
        rng = xorshift32(rng ^ {24'd0, stim_table[i].offset});
        for (int w = 0; w < 8; w++) begin
          rng = xorshift32(rng);
          cur.flit.data[w*32 +: 32] = rng;
        end
        rng = xorshift32(rng);
        cur.flit.crc = rng[15:0];
      end
      m_gen2_mode <= cur.gen2;
      {dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid,
       dstrm_crc, dstrm_crc_valid, dstrm_valid} <= cur.flit;
      if (!cur.gen2) cur.flit = clear_slot1(cur.flit);
      model_q.push_back(cur);
      @(negedge clk);
      // Beat halves carry the flit from 2 cycles back
      phy_ref = model_q[2].flit;
      if (tx_phy0[HALF_WIDTH-1:0] != phy_ref[HALF_WIDTH-1:0] ||
          tx_phy1[HALF_WIDTH-1:0] != phy_ref[FLIT_WIDTH-1:HALF_WIDTH]) begin
        $display("mismatch %s tx_phy: exp=%h act=%h%h", model_q[2].name, phy_ref,
                 tx_phy1[HALF_WIDTH-1:0], tx_phy0[HALF_WIDTH-1:0]);
        errors++;
      end
      if (!(tx_phy0[STB_BIT] && tx_phy1[STB_BIT])) begin
        $display("mismatch %s strobe: exp=11 act=%b%b", cur.name,
                 tx_phy1[STB_BIT], tx_phy0[STB_BIT]);
        errors++;
      end
      // One-hot marker that flips every beat
      mrk0 = tx_phy0[MRK_BIT];
      if (tx_phy1[MRK_BIT] == mrk0 || mrk0 == prev_mrk) begin
        $display("mismatch %s marker: exp=%b%b act=%b%b", cur.name,
                 prev_mrk, ~prev_mrk, tx_phy1[MRK_BIT], mrk0);
        errors++;
      end
      prev_mrk = mrk0;
      // Both debug words while both links are online
      if (tx_downstream_debug_status != dbg_exp || rx_upstream_debug_status != dbg_exp) begin
        $display("mismatch %s debug: exp=%h act=%h %h", cur.name, dbg_exp,
                 tx_downstream_debug_status, rx_upstream_debug_status);
        errors++;
      end
      // Loopback result from 4 cycles back
      cur = model_q.pop_front();
      want = up_mode ? cur.flit : clear_slot1(cur.flit);
      got = {ustrm_state, ustrm_protid, ustrm_data, ustrm_dvalid,
             ustrm_crc, ustrm_crc_valid, ustrm_valid};
      if (got != want) begin
        $display("mismatch %s ustrm: exp=%h act=%h", cur.name, want, got);
        errors++;
      end
    end

    // Going offline
    @(posedge clk);
    tx_online <= 1'b0;
    wait_for_level(3, "tx offline", cycles);

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
